// File: radio_ctrl_cfg.svh
/*
 * Build-time sizes for the radio control subsystem.
 * Buffer depths need not be powers of two, but NUM_USER_REGS must be one.
 * The user registers must fit in the 8-bit setting address space above the user base.
 */
`ifndef RADIO_CTRL_CFG_SVH
`define RADIO_CTRL_CFG_SVH

// Command and response buffer depths in beats
`define CTRL_FIFO_DEPTH 8
`define RESP_FIFO_DEPTH 8

// Number of user setting registers from the user base address on
`define NUM_USER_REGS 16

// Clock cycles allowed per test before a run is abandoned
`define WATCHDOG_CYCLES_PER_TEST 2000

`endif

// File: vita_pkt_pkg.sv
/*
 * Compressed VITA extension-context packet format on the command and
 * response streams. Only the header fields that the processor decodes
 * have types of their own.
 */
package vita_pkt_pkg;

   // One stream beat with the end-of-packet flag above the data word
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } beat_t;

   typedef logic [11:0] seqnum_t;
   typedef logic [31:0] sid_t;
   typedef logic [1:0]  pkt_class_t;

   // Extension-context packets are the only class that carries a command
   localparam pkt_class_t class_ext_ctx_c = 2'b10;

   // Response header type nibble and response length in 32-bit words
   localparam logic [3:0]  resp_type_c = 4'hC;
   localparam logic [15:0] resp_len_c  = 16'd6;

   // Command parsing states first, then the three response beats
   typedef enum logic [2:0] {
      rc_head,
      rc_time,
      rc_data,
      rc_dump,
      rc_resp_head,
      rc_resp_time,
      rc_resp_data
   } rc_state_t;

endpackage

// File: radio_regs_pkg.sv
/*
 * Setting bus address map and word types.
 * The bus is write-only with no acknowledgment; one strobe is one write.
 */
package radio_regs_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] readback_t;

   // Upper VITA time word, held until the lower word arrives
   localparam set_addr_t addr_time_hi = 8'd0;

   // Lower VITA time word; writing it loads the whole time
   localparam set_addr_t addr_time_lo = 8'd1;

   // Selects the user register shown in the upper readback half
   localparam set_addr_t addr_rb_sel = 8'd2;

   // First user setting register
   localparam set_addr_t addr_user_base = 8'd16;

endpackage

// File: axis_fifo.sv
/*
 * Stream buffer with a registered output stage in front of DEPTH entries.
 * An accepted beat shows at the output one cycle later at the earliest.
 * in_tready drops only while all DEPTH entries are in use.
 */
`timescale 1ns/100ps

module axis_fifo #(
   parameter int DEPTH = 8
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] in_tdata,
   input  logic        in_tlast,
   input  logic        in_tvalid,
   output logic        in_tready,
   output logic [63:0] out_tdata,
   output logic        out_tlast,
   output logic        out_tvalid,
   input  logic        out_tready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   vita_pkt_pkg::beat_t mem [DEPTH];
   vita_pkt_pkg::beat_t in_beat;
   vita_pkt_pkg::beat_t out_beat;
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                wr_en;
   logic                out_free;
   logic                mem_rd;
   logic                mem_wr;
   logic                bypass;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign in_beat   = '{last: in_tlast, data: in_tdata};
   assign in_tready = (count != CNT_W'(DEPTH));
   assign wr_en     = in_tvalid && in_tready;

   // The output register takes a new beat when empty or when its beat leaves
   assign out_free = !out_tvalid || out_tready;
   assign mem_rd   = out_free && (count != '0);

   // With nothing stored, an incoming beat goes straight to the output register
   assign bypass = out_free && (count == '0) && wr_en;
   assign mem_wr = wr_en && !bypass;

   always_ff @(posedge clk)
   begin
      if (mem_wr)
      begin
         mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         out_tvalid <= 1'b0;
      end
      else
      begin
         if (mem_wr)
         begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (mem_rd)
         begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CNT_W'(mem_wr) - CNT_W'(mem_rd);
         if (out_free)
         begin
            out_tvalid <= mem_rd || bypass;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_rd)
      begin
         out_beat <= mem[rd_ptr];
      end
      else if (bypass)
      begin
         out_beat <= in_beat;
      end
   end

   assign out_tdata = out_beat.data;
   assign out_tlast = out_beat.last;

   // Occupancy never passes the number of storage entries
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      count <= CNT_W'(DEPTH));

   // A stalled output beat stays on offer unchanged
   a_out_stable: assert property (@(posedge clk) disable iff (reset)
      out_tvalid && !out_tready |=> out_tvalid && $stable(out_beat));

endmodule

// File: radio_ctrl_proc.sv
/*
 * Parses one command packet at a time, holds a timed command until
 * vita_time reaches its timestamp, then writes the setting and answers
 * with a header, the send time and the readback word.
 * The response time beat follows vita_time while it waits for resp_tready.
 */
`timescale 1ns/100ps

module radio_ctrl_proc (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [63:0]               ctrl_tdata,
   input  logic                      ctrl_tlast,
   input  logic                      ctrl_tvalid,
   output logic                      ctrl_tready,
   output logic [63:0]               resp_tdata,
   output logic                      resp_tlast,
   output logic                      resp_tvalid,
   input  logic                      resp_tready,
   input  logic [63:0]               vita_time,
   output logic                      set_stb,
   output radio_regs_pkg::set_addr_t set_addr,
   output radio_regs_pkg::set_data_t set_data,
   input  logic                      radio_ready,
   input  radio_regs_pkg::readback_t readback
);

   vita_pkt_pkg::rc_state_t  state;
   vita_pkt_pkg::seqnum_t    seqnum;
   vita_pkt_pkg::sid_t       sid;
   vita_pkt_pkg::pkt_class_t hdr_class;
   vita_pkt_pkg::beat_t      resp_beat;
   logic                     hdr_has_time;
   logic                     has_time;
   logic                     is_cmd;
   logic                     now;
   logic                     late;
   logic                     go;
   logic [63:0]              cmd_time;

   assign hdr_class    = ctrl_tdata[63:62];
   assign hdr_has_time = ctrl_tdata[61];
   assign is_cmd       = (hdr_class == vita_pkt_pkg::class_ext_ctx_c);

   // A time beat is due once local time has reached it or already passed it
   assign now  = (vita_time == ctrl_tdata);
   assign late = (vita_time > ctrl_tdata);
   assign go   = now || late;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= vita_pkt_pkg::rc_head;
         has_time <= 1'b0;
      end
      else
      begin
         case (state)
            vita_pkt_pkg::rc_head:
               if (ctrl_tvalid)
               begin
                  has_time <= hdr_has_time;
                  // A command that ends at its header is answered without a write
                  if (is_cmd && ctrl_tlast)
                     state <= vita_pkt_pkg::rc_resp_head;
                  else if (is_cmd && hdr_has_time)
                     state <= vita_pkt_pkg::rc_time;
                  else if (is_cmd)
                     state <= vita_pkt_pkg::rc_data;
                  else if (!ctrl_tlast)
                     state <= vita_pkt_pkg::rc_dump;
               end
            vita_pkt_pkg::rc_time:
               if (ctrl_tvalid && go)
                  state <= ctrl_tlast ? vita_pkt_pkg::rc_resp_head : vita_pkt_pkg::rc_data;
            vita_pkt_pkg::rc_data:
               if (ctrl_tvalid && radio_ready)
                  state <= ctrl_tlast ? vita_pkt_pkg::rc_resp_head : vita_pkt_pkg::rc_dump;
            vita_pkt_pkg::rc_dump:
               if (ctrl_tvalid && ctrl_tlast)
                  state <= vita_pkt_pkg::rc_resp_head;
            vita_pkt_pkg::rc_resp_head:
               if (resp_tready)
                  state <= vita_pkt_pkg::rc_resp_time;
            vita_pkt_pkg::rc_resp_time:
               if (resp_tready)
                  state <= vita_pkt_pkg::rc_resp_data;
            vita_pkt_pkg::rc_resp_data:
               if (resp_tready)
                  state <= vita_pkt_pkg::rc_head;
            default:
               state <= vita_pkt_pkg::rc_head;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == vita_pkt_pkg::rc_head && ctrl_tvalid)
      begin
         seqnum <= ctrl_tdata[59:48];
         sid    <= ctrl_tdata[31:0];
      end
      if (state == vita_pkt_pkg::rc_time && ctrl_tvalid && go)
      begin
         cmd_time <= ctrl_tdata;
      end
   end

   always_comb
   begin
      case (state)
         vita_pkt_pkg::rc_head: ctrl_tready = 1'b1;
         vita_pkt_pkg::rc_time: ctrl_tready = go;
         vita_pkt_pkg::rc_data: ctrl_tready = radio_ready;
         vita_pkt_pkg::rc_dump: ctrl_tready = 1'b1;
         default:               ctrl_tready = 1'b0;
      endcase
   end

   // The payload beat is the setting write itself
   assign set_stb  = (state == vita_pkt_pkg::rc_data) && radio_ready && ctrl_tvalid;
   assign set_addr = ctrl_tdata[39:32];
   assign set_data = ctrl_tdata[31:0];

   always_comb
   begin
      case (state)
         vita_pkt_pkg::rc_resp_head:
            resp_beat = '{last: 1'b0, data: {vita_pkt_pkg::resp_type_c, seqnum,
                          vita_pkt_pkg::resp_len_c, sid[15:0], sid[31:16]}};
         vita_pkt_pkg::rc_resp_time: resp_beat = '{last: 1'b0, data: vita_time};
         vita_pkt_pkg::rc_resp_data: resp_beat = '{last: 1'b1, data: readback};
         default:                    resp_beat = '0;
      endcase
   end

   assign resp_tdata  = resp_beat.data;
   assign resp_tlast  = resp_beat.last;
   assign resp_tvalid = state inside {vita_pkt_pkg::rc_resp_head, vita_pkt_pkg::rc_resp_time,
                                      vita_pkt_pkg::rc_resp_data};

   // A setting write retires its payload beat, so no beat is written twice
   a_stb_once: assert property (@(posedge clk) disable iff (reset)
      set_stb |-> ctrl_tready ##1 !set_stb);

   a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      resp_tvalid && !resp_tready |=> resp_tvalid);

   // A timed command never reaches the setting bus before its timestamp
   a_not_early: assert property (@(posedge clk) disable iff (reset)
      set_stb && has_time |-> vita_time >= cmd_time);

endmodule

// File: setting_reg_bank.sv
/*
 * User setting registers with a readback select and a strobe counter.
 * NUM_REGS must be a power of two so that every select value is mapped.
 * Every strobe counts, including writes to the time words and unmapped addresses.
 */
`timescale 1ns/100ps

module setting_reg_bank #(
   parameter int NUM_REGS = 16
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      set_stb,
   input  radio_regs_pkg::set_addr_t set_addr,
   input  radio_regs_pkg::set_data_t set_data,
   output radio_regs_pkg::readback_t readback
);

   localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

   radio_regs_pkg::set_data_t user_regs [NUM_REGS];
   radio_regs_pkg::set_addr_t user_offset;
   logic [IDX_W-1:0]          rb_sel;
   logic [31:0]               strobe_count;
   logic                      user_hit;

   assign user_offset = set_addr - radio_regs_pkg::addr_user_base;
   assign user_hit    = (set_addr >= radio_regs_pkg::addr_user_base) &&
                        (int'(user_offset) < NUM_REGS);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            user_regs[i] <= '0;
         end
         rb_sel       <= '0;
         strobe_count <= '0;
      end
      else if (set_stb)
      begin
         strobe_count <= strobe_count + 32'd1;
         if (user_hit)
         begin
            user_regs[user_offset[IDX_W-1:0]] <= set_data;
         end
         if (set_addr == radio_regs_pkg::addr_rb_sel)
         begin
            rb_sel <= set_data[IDX_W-1:0];
         end
      end
   end

   // Straight from the registers, so a write shows from the next cycle on
   assign readback = {user_regs[rb_sel], strobe_count};

endmodule

// File: radio_timekeeper.sv
/*
 * Free-running 64-bit VITA time, one tick per clock.
 * Loading takes two writes: the upper word is held until the lower word
 * arrives, and the full value appears after the edge of the lower write.
 */
`timescale 1ns/100ps

module radio_timekeeper (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      set_stb,
   input  radio_regs_pkg::set_addr_t set_addr,
   input  radio_regs_pkg::set_data_t set_data,
   output logic [63:0]               vita_time
);

   radio_regs_pkg::set_data_t time_hi;
   logic                      hi_write;
   logic                      time_load;

   assign hi_write  = set_stb && (set_addr == radio_regs_pkg::addr_time_hi);
   assign time_load = set_stb && (set_addr == radio_regs_pkg::addr_time_lo);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vita_time <= '0;
         time_hi   <= '0;
      end
      else
      begin
         if (hi_write)
         begin
            time_hi <= set_data;
         end
         if (time_load)
         begin
            vita_time <= {time_hi, set_data};
         end
         else
         begin
            vita_time <= vita_time + 64'd1;
         end
      end
   end

   // Time only jumps on a load; otherwise it moves forward by exactly one
   a_time_steps: assert property (@(posedge clk) disable iff (reset)
      !time_load |=> vita_time == $past(vita_time) + 64'd1);

endmodule

// File: radio_ctrl_top.sv
/*
 * Radio control subsystem: command buffer, control processor, setting
 * registers, VITA timekeeper and response buffer on one clock.
 * radio_ready from the front end must rise for setting writes to proceed.
 */
`timescale 1ns/100ps
`include "radio_ctrl_cfg.svh"

module radio_ctrl_top (
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] ctrl_tdata,
   input  logic        ctrl_tlast,
   input  logic        ctrl_tvalid,
   output logic        ctrl_tready,
   output logic [63:0] resp_tdata,
   output logic        resp_tlast,
   output logic        resp_tvalid,
   input  logic        resp_tready,
   input  logic        radio_ready,
   output logic [63:0] vita_time
);

   // Buffered command stream into the processor and its response stream out
   wire vita_pkt_pkg::beat_t  cmd_beat;
   logic                      cmd_tvalid;
   logic                      cmd_tready;
   wire vita_pkt_pkg::beat_t  rsp_beat;
   logic                      rsp_tvalid;
   logic                      rsp_tready;

   logic                      set_stb;
   radio_regs_pkg::set_addr_t set_addr;
   radio_regs_pkg::set_data_t set_data;
   radio_regs_pkg::readback_t readback;

   axis_fifo #(.DEPTH(`CTRL_FIFO_DEPTH)) ctrl_fifo (
      .clk, .reset,
      .in_tdata(ctrl_tdata), .in_tlast(ctrl_tlast),
      .in_tvalid(ctrl_tvalid), .in_tready(ctrl_tready),
      .out_tdata(cmd_beat.data), .out_tlast(cmd_beat.last),
      .out_tvalid(cmd_tvalid), .out_tready(cmd_tready)
   );

   radio_ctrl_proc proc (
      .clk, .reset,
      .ctrl_tdata(cmd_beat.data), .ctrl_tlast(cmd_beat.last),
      .ctrl_tvalid(cmd_tvalid), .ctrl_tready(cmd_tready),
      .resp_tdata(rsp_beat.data), .resp_tlast(rsp_beat.last),
      .resp_tvalid(rsp_tvalid), .resp_tready(rsp_tready),
      .vita_time, .set_stb, .set_addr, .set_data,
      .radio_ready, .readback
   );

   setting_reg_bank #(.NUM_REGS(`NUM_USER_REGS)) regs (
      .clk, .reset, .set_stb, .set_addr, .set_data, .readback
   );

   radio_timekeeper timekeeper (
      .clk, .reset, .set_stb, .set_addr, .set_data, .vita_time
   );

   axis_fifo #(.DEPTH(`RESP_FIFO_DEPTH)) resp_fifo (
      .clk, .reset,
      .in_tdata(rsp_beat.data), .in_tlast(rsp_beat.last),
      .in_tvalid(rsp_tvalid), .in_tready(rsp_tready),
      .out_tdata(resp_tdata), .out_tlast(resp_tlast),
      .out_tvalid(resp_tvalid), .out_tready(resp_tready)
   );

endmodule

// File: radio_ctrl_tb.sv
/*
 * Testbench for the radio control top level, driven from a command table.
 * Timed rows and time loads wait until every earlier response is in,
 * so that their time base is settled. Untimed rows stream back to back.
 */
`timescale 1ns/100ps
`include "radio_ctrl_cfg.svh"

module radio_ctrl_tb;

   localparam int num_rows = 18;
   localparam int t_none = 0;
   localparam int t_rel = 1;
   localparam int t_abs = 2;
   localparam logic [1:0] cls_cmd = vita_pkt_pkg::class_ext_ctx_c;
   localparam logic [1:0] cls_data = 2'b00;

   typedef struct {
      string       name;
      logic [1:0]  cls;
      int          tmode;
      logic [63:0] tval;
      logic [7:0]  addr;
      logic [31:0] data;
      int          len;
      int          rdy_pct;
      int          rsp_pct;
      bit          resp;
   } row_t;

   logic        clk;
   logic        reset;
   logic [63:0] ctrl_tdata;
   logic        ctrl_tlast;
   logic        ctrl_tvalid;
   logic        ctrl_tready;
   logic [63:0] resp_tdata;
   logic        resp_tlast;
   logic        resp_tvalid;
   logic        resp_tready;
   logic        radio_ready;
   logic [63:0] vita_time;

   row_t        rows [num_rows];
   logic [11:0] seq_of [num_rows];
   logic [31:0] sid_of [num_rows];
   logic [63:0] req_time [num_rows];
   logic [63:0] sent_time [num_rows];
   logic [63:0] exp_rb [num_rows];
   logic [63:0] load_time [num_rows];
   bit          is_load [num_rows];

   // Register file model with user registers, readback select, strobe count and time upper word
   logic [31:0] model_user [`NUM_USER_REGS];
   int          model_sel;
   logic [31:0] model_count;
   logic [31:0] model_time_hi;

   logic [63:0] rsp_data [3];
   logic [63:0] rsp_time [3];
   logic [2:0]  rsp_last;
   int          driven;
   int          checked;
   int          rdy_pct;
   int          errors;
   int          test_errors;
   int          failed_tests;

   radio_ctrl_top dut (
      .clk, .reset,
      .ctrl_tdata, .ctrl_tlast, .ctrl_tvalid, .ctrl_tready,
      .resp_tdata, .resp_tlast, .resp_tvalid, .resp_tready,
      .radio_ready, .vita_time
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // The front end toggles readiness at the rate of the row being driven
   initial
   begin
      radio_ready = 1'b1;
      forever
      begin
         @(negedge clk);
         radio_ready = (int'($urandom_range(99)) < rdy_pct);
      end
   end

   initial
   begin
      repeat (num_rows * `WATCHDOG_CYCLES_PER_TEST) @(posedge clk);
      $display("Watchdog expired with %0d of %0d tests finished", checked, num_rows);
      $display("TEST FAIL");
      $finish;
   end

   task automatic load_table();
      rows[0]  = '{"rb_sel_write", cls_cmd, t_none, 64'd0, 8'd2, 32'd5, 2, 100, 100, 1'b1};
      rows[1]  = '{"user5_write", cls_cmd, t_none, 64'd0, 8'd21, 32'hcafe_0005, 2, 100, 100, 1'b1};
      rows[2]  = '{"user3_write", cls_cmd, t_none, 64'd0, 8'd19, 32'h1234_5678, 2, 100, 100, 1'b1};
      rows[3]  = '{"future_time", cls_cmd, t_rel, 64'd300, 8'd21, 32'hbeef_0001, 3, 100, 100, 1'b1};
      rows[4]  = '{"past_time", cls_cmd, t_abs, 64'd10, 8'd20, 32'h0000_0a0a, 3, 100, 100, 1'b1};
      rows[5]  = '{"timed_no_payload", cls_cmd, t_rel, 64'd40, 8'd0, 32'd0, 2, 100, 100, 1'b1};
      rows[6]  = '{"data_single", cls_data, t_none, 64'd0, 8'd22, 32'hdead, 1, 100, 100, 1'b0};
      rows[7]  = '{"data_multi", cls_data, t_none, 64'd0, 8'd23, 32'hdead, 3, 100, 100, 1'b1};
      rows[8]  = '{"after_data", cls_cmd, t_none, 64'd0, 8'd22, 32'h0000_2222, 2, 100, 100, 1'b1};
      rows[9]  = '{"burst_0", cls_cmd, t_none, 64'd0, 8'd16, 32'h0000_b000, 2, 40, 30, 1'b1};
      rows[10] = '{"burst_1", cls_cmd, t_none, 64'd0, 8'd2, 32'd1, 2, 40, 30, 1'b1};
      rows[11] = '{"burst_2", cls_cmd, t_none, 64'd0, 8'd17, 32'h0000_b002, 2, 40, 30, 1'b1};
      rows[12] = '{"burst_3", cls_cmd, t_none, 64'd0, 8'd99, 32'h0000_b003, 2, 40, 30, 1'b1};
      rows[13] = '{"burst_4", cls_cmd, t_none, 64'd0, 8'd18, 32'h0000_b004, 2, 40, 30, 1'b1};
      rows[14] = '{"load_time_hi", cls_cmd, t_none, 64'd0, 8'd0, 32'h12, 2, 100, 100, 1'b1};
      rows[15] = '{"load_time_lo", cls_cmd, t_none, 64'd0, 8'd1, 32'h3400_0000, 2, 100, 100, 1'b1};
      rows[16] = '{"future_after_load", cls_cmd, t_rel, 64'd200, 8'd24, 32'hb0b, 3, 100, 100, 1'b1};
      rows[17] = '{"past_after_load", cls_cmd, t_abs, 64'd100, 8'd25, 32'hc0c, 3, 100, 100, 1'b1};
   endtask

   task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
      model_count = model_count + 32'd1;
      if (addr >= radio_regs_pkg::addr_user_base && int'(addr) - 16 < `NUM_USER_REGS)
      begin
         model_user[int'(addr) - 16] = data;
      end
      if (addr == radio_regs_pkg::addr_rb_sel)
      begin
         model_sel = int'(data % 32'(`NUM_USER_REGS));
      end
      if (addr == radio_regs_pkg::addr_time_hi)
      begin
         model_time_hi = data;
      end
   endtask

   // Called on a falling edge; returns on the falling edge after the transfer
   task automatic send_beat(input logic [63:0] data, input logic last);
      logic taken;
      ctrl_tdata  = data;
      ctrl_tlast  = last;
      ctrl_tvalid = 1'b1;
      taken       = 1'b0;
      while (!taken)
      begin
         taken = ctrl_tready;
         @(negedge clk);
      end
   endtask

   task automatic send_packet(input int i);
      logic [63:0] beats [$];
      logic        timed;
      timed = (rows[i].tmode != t_none);
      beats.push_back({rows[i].cls, timed, 1'b0, seq_of[i], 16'h0, sid_of[i]});
      if (timed)
      begin
         beats.push_back(req_time[i]);
      end
      while (beats.size() < rows[i].len)
      begin
         beats.push_back({24'h0, rows[i].addr, rows[i].data});
      end
      for (int k = 0; k < beats.size(); k++)
      begin
         send_beat(beats[k], k == beats.size() - 1);
      end
      ctrl_tvalid = 1'b0;
   endtask

   task automatic drive_all();
      bit writes;
      for (int i = 0; i < num_rows; i++)
      begin
         if (rows[i].tmode != t_none || rows[i].addr == radio_regs_pkg::addr_time_lo)
         begin
            while (checked < i)
            begin
               @(negedge clk);
            end
         end
         rdy_pct   = rows[i].rdy_pct;
         seq_of[i] = 12'(i * 5 + 3);
         sid_of[i] = $urandom;
         sent_time[i] = vita_time;
         req_time[i] = (rows[i].tmode == t_rel) ? vita_time + rows[i].tval : rows[i].tval;
         // Only a command long enough to reach its payload beat writes a setting
         writes = (rows[i].cls == cls_cmd) && (rows[i].len >= ((rows[i].tmode != t_none) ? 3 : 2));
         is_load[i] = writes && (rows[i].addr == radio_regs_pkg::addr_time_lo);
         load_time[i] = {model_time_hi, rows[i].data};
         if (writes)
         begin
            apply_write(rows[i].addr, rows[i].data);
         end
         exp_rb[i] = {model_user[model_sel], model_count};
         send_packet(i);
         driven = i + 1;
      end
   endtask

   task automatic collect_response(input int pct);
      int n;
      n = 0;
      while (n < 3)
      begin
         @(negedge clk);
         resp_tready = (int'($urandom_range(99)) < pct);
         if (resp_tvalid && resp_tready)
         begin
            rsp_data[n] = resp_tdata;
            rsp_last[n] = resp_tlast;
            rsp_time[n] = vita_time;
            n++;
         end
      end
   endtask

   task automatic log_mismatch(input int i, input string what, input logic [63:0] exp,
                               input logic [63:0] act);
      $display("MISMATCH %s %s: expected %h, actual %h", rows[i].name, what, exp, act);
      test_errors++;
   endtask

   task automatic check_response(input int i);
      logic [63:0] exp_hdr;
      exp_hdr = {4'hC, seq_of[i], 16'd6, sid_of[i][15:0], sid_of[i][31:16]};
      assert (rsp_data[0] == exp_hdr)
         else log_mismatch(i, "header", exp_hdr, rsp_data[0]);
      assert (rsp_last == 3'b100)
         else log_mismatch(i, "tlast pattern", 64'h4, 64'(rsp_last));
      assert (rsp_data[2] == exp_rb[i])
         else log_mismatch(i, "readback", exp_rb[i], rsp_data[2]);
      if (rows[i].tmode != t_none)
      begin
         assert (rsp_time[0] >= req_time[i])
         else
         begin
            $display("%s: response arrived at time %0d, before the requested time %0d",
                     rows[i].name, rsp_time[0], req_time[i]);
            test_errors++;
         end
         assert (rsp_data[1] >= req_time[i])
            else log_mismatch(i, "time word (at least)", req_time[i], rsp_data[1]);
      end
      // A command stamped in the past goes out within a few cycles of being sent
      if (rows[i].tmode == t_abs)
      begin
         assert (rsp_data[1] < sent_time[i] + 64'd50)
         else
         begin
            $display("%s: past command was held, time word %0d for a command sent at %0d",
                     rows[i].name, rsp_data[1], sent_time[i]);
            test_errors++;
         end
      end
      if (is_load[i])
      begin
         assert (rsp_time[2] >= load_time[i] && rsp_time[2] < load_time[i] + 64'd50)
            else log_mismatch(i, "vita_time after load", load_time[i], rsp_time[2]);
      end
   endtask

   task automatic check_all();
      for (int i = 0; i < num_rows; i++)
      begin
         while (driven <= i)
         begin
            @(negedge clk);
         end
         test_errors = 0;
         if (rows[i].resp)
         begin
            collect_response(rows[i].rsp_pct);
            check_response(i);
         end
         if (test_errors == 0)
            $display("%s: ok", rows[i].name);
         else
            $display("%s: failed with %0d errors", rows[i].name, test_errors);
         errors = errors + test_errors;
         failed_tests = failed_tests + ((test_errors != 0) ? 1 : 0);
         checked = i + 1;
      end
   endtask

   initial
   begin
      void'($urandom(32'h5f3e_8c02));
      load_table();
      for (int r = 0; r < `NUM_USER_REGS; r++)
      begin
         model_user[r] = '0;
      end
      model_sel     = 0;
      model_count   = '0;
      model_time_hi = '0;
      driven       = 0;
      checked      = 0;
      errors       = 0;
      test_errors  = 0;
      failed_tests = 0;
      rdy_pct      = 100;
      reset        = 1'b1;
      ctrl_tdata   = '0;
      ctrl_tlast   = 1'b0;
      ctrl_tvalid  = 1'b0;
      resp_tready  = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      fork
         drive_all();
         check_all();
      join
      $display("%0d tests, %0d failed, %0d errors", num_rows, failed_tests, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: sim.f
+incdir+.
vita_pkt_pkg.sv
radio_regs_pkg.sv
axis_fifo.sv
radio_ctrl_proc.sv
setting_reg_bank.sv
radio_timekeeper.sv
radio_ctrl_top.sv
radio_ctrl_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = radio_ctrl_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TEST FAIL
PASS_MSG = TEST PASS

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
